/* run_sim.sh */
#!/bin/sh
# Compile and run the packet tap testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_snoop_top -Mdir obj_dir -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_snoop_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "PASS: all tests" "$LOG"; then
    exit 0
fi
exit 1

/* sources.f */
verilog/snoop_stream_pkg.sv
verilog/snoop_core_pkg.sv
verilog/snoop_capture.sv
verilog/packet_ram.sv
verilog/checksum_core.sv
verilog/snoop_stats.sv
verilog/snoop_top.sv
testbench/tb_snoop_top.sv

/* testbench/tb_snoop_top.sv */
`timescale 1ns/100ps
`default_nettype none

// Self-checking testbench for the packet tap
module tb_snoop_top import snoop_stream_pkg::*, snoop_core_pkg::*; ();

    localparam int CLK_NS = 40;
    // Upper bound on packets over all tests
    localparam int MAX_PKTS = 50;
    // Cycles per packet for beats with gaps, result latency and idle time
    localparam int PKT_CYCLES = 120;
    localparam int WATCHDOG_NS = MAX_PKTS * PKT_CYCLES * CLK_NS * 4;
    // Longest wait for one result covers a full buffer plus margin
    localparam int RESULT_WAIT = 600;

    logic                   clk;
    logic                   rst;
    logic [DATA_W-1:0]      sn_tdata;
    logic [KEEP_W-1:0]      sn_tkeep;
    logic                   sn_tvalid;
    logic                   sn_tready;
    logic                   sn_tlast;
    logic                   result_valid;
    logic [CSUM_W-1:0]      result_csum;
    logic [LEN_W-1:0]       result_len;
    logic [CNT_W-1:0]       pkt_count;
    logic [CNT_W-1:0]       drop_count;
    logic [BYTES_CNT_W-1:0] byte_count;

    logic [31:0] lcg_state;
    // Predicted capture phase
    // 0 drops the next packet, 1 captures it and 2 means the core is busy
    int phase;
    int error_count;
    int check_count;
    int test_count;
    int failed_tests;
    int results_seen;
    int predicted_drops;
    int predicted_pkts;
    int unsigned captured_bytes;
    int partial_lens[5] = '{1, 7, 13, 30, 99};

    // Expected results with one entry per captured packet
    logic [CSUM_W-1:0] exp_csum_q[$];
    logic [LEN_W-1:0]  exp_len_q[$];

    snoop_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .sn_tdata_i     (sn_tdata),
        .sn_tkeep_i     (sn_tkeep),
        .sn_tvalid_i    (sn_tvalid),
        .sn_tready_i    (sn_tready),
        .sn_tlast_i     (sn_tlast),
        .result_valid_o (result_valid),
        .result_csum_o  (result_csum),
        .result_len_o   (result_len),
        .pkt_count_o    (pkt_count),
        .drop_count_o   (drop_count),
        .byte_count_o   (byte_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // LCG whose upper state bits feed the output
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'd0, lcg_state[30:15]};
    endfunction

    function automatic int rand_len(input int unsigned max_len);
        return 1 + int'(next_rand() % max_len);
    endfunction

    function automatic logic [DATA_W-1:0] rand_word();
        logic [DATA_W-1:0] w;
        for (int i = 0; i < DATA_W / 16; i++) begin
            w[16*i +: 16] = 16'(next_rand());
        end
        return w;
    endfunction

    // Ones'-complement sum of big-endian byte pairs with a zero-padded odd tail
    function automatic logic [CSUM_W-1:0] ref_csum(input logic [7:0] bytes[$]);
        int unsigned sum;
        sum = 0;
        for (int i = 0; i < bytes.size(); i += 2) begin
            sum += {16'd0, bytes[i], (i + 1 < bytes.size()) ? bytes[i + 1] : 8'h00};
        end
        while (sum > 32'hFFFF) begin
            sum = (sum & 32'hFFFF) + (sum >> 16);
        end
        return ~sum[15:0];
    endfunction

    task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    // One cycle of stream inputs
    task automatic drive(input logic [DATA_W-1:0] data, input logic [KEEP_W-1:0] keep,
                         input logic valid, input logic ready, input logic last);
        @(posedge clk);
        sn_tdata <= data;
        sn_tkeep <= keep;
        sn_tvalid <= valid;
        sn_tready <= ready;
        sn_tlast <= last;
    endtask

    task automatic reset_dut();
        @(posedge clk);
        rst <= 1'b1;
        sn_tvalid <= 1'b0;
        sn_tready <= 1'b0;
        sn_tlast <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        exp_csum_q.delete();
        exp_len_q.delete();
        phase = 0;
        results_seen = 0;
        predicted_drops = 0;
        predicted_pkts = 0;
        captured_bytes = 0;
    endtask

    // Wait for every predicted result and let the core rearm
    task automatic wait_result();
        int waited;
        waited = 0;
        while (exp_len_q.size() != 0 && waited < RESULT_WAIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_len_q.size() != 0) begin
            error_count++;
            $display("Timeout at %0t ns: no result from the DUT within %0d cycles",
                     $time, RESULT_WAIT);
            exp_csum_q.delete();
            exp_len_q.delete();
        end
        repeat (3) @(posedge clk);
        phase = 0;
    endtask

    // Overlap sends while the core is still summing
    task automatic send_packet(input int len, input bit gaps, input bit overlap);
        logic [7:0]        bytes[$];
        logic [DATA_W-1:0] data;
        logic [KEEP_W-1:0] keep;
        int                nbeats;
        int                beat;
        int                idx;
        if (phase == 2 && !overlap) begin
            wait_result();
        end
        for (int i = 0; i < len; i++) begin
            bytes.push_back(8'(next_rand()));
        end
        // Predict the outcome from the capture state rule
        if (phase == 1) begin
            exp_csum_q.push_back(ref_csum(bytes));
            exp_len_q.push_back(LEN_W'(len));
            captured_bytes += len;
            predicted_pkts++;
            phase = 2;
        end else begin
            predicted_drops++;
            if (phase == 0) begin
                phase = 1;
            end
        end
        nbeats = (len + KEEP_W - 1) / KEEP_W;
        beat = 0;
        while (beat < nbeats) begin
            if (gaps && next_rand() % 4 == 0) begin
                // Beat not taken with junk data and a random last flag
                if (next_rand() % 2 == 0) begin
                    drive(rand_word(), '1, 1'b0, 1'b1, 1'(next_rand()));
                end else begin
                    drive(rand_word(), '1, 1'b1, 1'b0, 1'(next_rand()));
                end
            end else begin
                // Lanes past the end carry junk with TKEEP low
                for (int l = 0; l < KEEP_W; l++) begin
                    idx = beat * KEEP_W + l;
                    keep[l] = (idx < len);
                    data[8*l +: 8] = (idx < len) ? bytes[idx] : 8'(next_rand());
                end
                drive(data, keep, 1'b1, 1'b1, beat == nbeats - 1);
                beat++;
            end
        end
        drive(rand_word(), '0, 1'b0, 1'b0, 1'b0);
        drive(rand_word(), '0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        test_count++;
        if (error_count == errors_at_start) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            failed_tests++;
            $display("Test %0d %s: %0d errors", test_count, name,
                     error_count - errors_at_start);
        end
    endtask

    // Compare each result with the oldest predicted packet
    always @(negedge clk) begin
        if (result_valid === 1'b1) begin
            if (exp_len_q.size() == 0) begin
                error_count++;
                $display("Unexpected result at %0t ns: no captured packet was predicted",
                         $time);
            end else begin
                check("result_len_o", 64'(result_len), 64'(exp_len_q.pop_front()));
                check("result_csum_o", 64'(result_csum), 64'(exp_csum_q.pop_front()));
                results_seen++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog: run exceeded %0d ns, DUT or testbench is stuck", WATCHDOG_NS);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        int start_err;
        rst = 1'b1;
        sn_tdata = '0;
        sn_tkeep = '0;
        sn_tvalid = 1'b0;
        sn_tready = 1'b0;
        sn_tlast = 1'b0;
        lcg_state = 32'd9796;
        phase = 0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        failed_tests = 0;
        results_seen = 0;
        predicted_drops = 0;
        predicted_pkts = 0;
        captured_bytes = 0;

        // First packet after reset is dropped and the second captured
        start_err = error_count;
        reset_dut();
        send_packet(40, 1'b0, 1'b0);
        send_packet(53, 1'b0, 1'b0);
        wait_result();
        check("drop_count_o", 64'(drop_count), 64'd1);
        check("pkt_count_o", 64'(pkt_count), 64'd1);
        check("result count", 64'(results_seen), 64'd1);
        finish_test("sync drop and capture", start_err);

        // Odd and partial last beats
        start_err = error_count;
        reset_dut();
        for (int i = 0; i < 5; i++) begin
            send_packet(rand_len(64), 1'b0, 1'b0);
            send_packet(partial_lens[i], 1'b0, 1'b0);
        end
        wait_result();
        check("result count", 64'(results_seen), 64'd5);
        finish_test("partial last beat", start_err);

        // Idle cycles inside packets
        start_err = error_count;
        reset_dut();
        for (int i = 0; i < 3; i++) begin
            send_packet(rand_len(120), 1'b1, 1'b0);
            send_packet(rand_len(120), 1'b1, 1'b0);
        end
        wait_result();
        check("result count", 64'(results_seen), 64'd3);
        finish_test("gaps in the beat stream", start_err);

        // Two short packets end while the core sums the long one
        start_err = error_count;
        reset_dut();
        send_packet(20, 1'b0, 1'b0);
        send_packet(64, 1'b0, 1'b0);
        send_packet(8, 1'b0, 1'b1);
        send_packet(16, 1'b0, 1'b1);
        send_packet(24, 1'b0, 1'b0);
        send_packet(36, 1'b0, 1'b0);
        wait_result();
        check("drop_count_o", 64'(drop_count), 64'(predicted_drops));
        check("pkt_count_o", 64'(pkt_count), 64'd2);
        check("result count", 64'(results_seen), 64'd2);
        finish_test("overrun drops", start_err);

        // Random run with counters checked against the prediction
        start_err = error_count;
        reset_dut();
        for (int i = 0; i < 20; i++) begin
            send_packet(rand_len(160), 1'(next_rand()), 1'b0);
        end
        wait_result();
        check("result count", 64'(results_seen), 64'(predicted_pkts));
        check("pkt_count_o", 64'(pkt_count), 64'(predicted_pkts));
        check("byte_count_o", 64'(byte_count), 64'(captured_bytes));
        check("drop_count_o", 64'(drop_count), 64'(predicted_drops));
        finish_test("statistics", start_err);

        // Reset while a captured packet is being written
        start_err = error_count;
        reset_dut();
        send_packet(32, 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            drive(rand_word(), '1, 1'b1, 1'b1, 1'b0);
        end
        reset_dut();
        @(negedge clk);
        check("pkt_count_o", 64'(pkt_count), 64'd0);
        check("drop_count_o", 64'(drop_count), 64'd0);
        check("byte_count_o", 64'(byte_count), 64'd0);
        // Quiet stretch in which no result may appear
        repeat (20) @(posedge clk);
        send_packet(28, 1'b0, 1'b0);
        send_packet(45, 1'b0, 1'b0);
        wait_result();
        check("drop_count_o", 64'(drop_count), 64'd1);
        check("pkt_count_o", 64'(pkt_count), 64'd1);
        check("result count", 64'(results_seen), 64'd1);
        finish_test("reset mid-packet", start_err);

        $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/checksum_core.sv */
`timescale 1ns/100ps
`default_nettype none

// Owns the packet buffer and checksums each captured packet
module checksum_core import snoop_stream_pkg::*, snoop_core_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // Capture side
    input  logic              wr_en_i,
    input  logic [INC_W-1:0]  byte_inc_i,
    input  logic              done_i,
    input  logic              rdy_ack_i,
    output logic              buf_rdy_o,
    // Buffer read port
    output logic              rd_en_o,
    output logic [ADDR_W-1:0] rd_addr_o,
    input  logic [DATA_W-1:0] rd_data_i,
    // Result
    output logic              result_valid_o,
    output logic [CSUM_W-1:0] result_csum_o,
    output logic [LEN_W-1:0]  result_len_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_CLAIM,
        S_READ,
        S_DRAIN
    } core_state_t;

    core_state_t state;

    // Length tracking during the write
    logic [LEN_W-1:0]  len_acc;
    logic [LEN_W-1:0]  len_next;
    logic [LEN_W-1:0]  pkt_len;
    logic [ADDR_W-1:0] last_word;
    logic [ADDR_W-1:0] last_word_next;

    // Read pipeline, aligned with rd_data_i
    logic              rd_vld;
    logic              rd_last;
    logic [ADDR_W-1:0] rd_idx;
    logic              fold_go;

    // Summing datapath
    logic [LEN_W-1:0]       byte_pos;
    logic [DATA_W-1:0]      masked;
    logic [CSUM_W+1:0]      word_sum;
    logic [CSUM_W+ADDR_W+1:0] acc;
    logic [CSUM_W:0]        fold1;
    logic [CSUM_W-1:0]      fold2;

    // Buffer is free only when idle
    assign buf_rdy_o = (state == S_IDLE);
    assign rd_en_o = (state == S_READ);

    // The done beat is also written, so its bytes count too
    assign len_next = len_acc + (wr_en_i ? LEN_W'(byte_inc_i) : LEN_W'(0));
    // Index of the last word holding packet bytes
    assign last_word_next = (len_next == '0) ? '0 :
                            ADDR_W'((len_next - LEN_W'(1)) / LEN_W'(KEEP_W));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
            rd_addr_o <= '0;
            rd_vld <= 1'b0;
            rd_last <= 1'b0;
            fold_go <= 1'b0;
            result_valid_o <= 1'b0;
        end else begin
            rd_vld <= rd_en_o;
            rd_last <= rd_en_o && (rd_addr_o == last_word);
            fold_go <= rd_vld && rd_last;
            result_valid_o <= fold_go;
            case (state)
                S_IDLE: begin
                    if (rdy_ack_i) begin
                        state <= S_CLAIM;
                    end
                end
                S_CLAIM: begin
                    if (done_i) begin
                        rd_addr_o <= '0;
                        state <= S_READ;
                    end
                end
                S_READ: begin
                    // One word per cycle up to the last one
                    rd_addr_o <= rd_addr_o + ADDR_W'(1);
                    if (rd_addr_o == last_word) begin
                        state <= S_DRAIN;
                    end
                end
                S_DRAIN: begin
                    // Hand the buffer back the cycle after the result
                    if (result_valid_o) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        rd_idx <= rd_addr_o;
        if (state == S_IDLE) begin
            len_acc <= '0;
        end else if (wr_en_i) begin
            len_acc <= len_next;
        end
        if (state == S_CLAIM && done_i) begin
            pkt_len <= len_next;
            last_word <= last_word_next;
            acc <= '0;
        end else if (rd_vld) begin
            acc <= acc + ($bits(acc))'(word_sum);
        end
        if (fold_go) begin
            // Internet style, complement of the ones'-complement sum
            result_csum_o <= ~fold2;
            result_len_o <= pkt_len;
        end
    end

    // Zero the bytes past the packet end, then add the 16-bit lanes
    // Byte 2k is the high byte and byte 2k+1 the low byte of lane k
    always_comb begin
        masked = '0;
        byte_pos = '0;
        word_sum = '0;
        for (int b = 0; b < KEEP_W; b++) begin
            byte_pos = LEN_W'(rd_idx) * LEN_W'(KEEP_W) + LEN_W'(b);
            if (byte_pos < pkt_len) begin
                masked[8*b +: 8] = rd_data_i[8*b +: 8];
            end
        end
        for (int k = 0; k < KEEP_W / 2; k++) begin
            word_sum = word_sum + (CSUM_W+2)'({masked[16*k +: 8], masked[16*k+8 +: 8]});
        end
    end

    // End-around carry, two steps cover the accumulator width
    always_comb begin
        fold1 = (CSUM_W+1)'(acc[CSUM_W-1:0]) + (CSUM_W+1)'(acc[$bits(acc)-1:CSUM_W]);
        fold2 = fold1[CSUM_W-1:0] + CSUM_W'(fold1[CSUM_W]);
    end

    // Capture must not finish a packet before the last one is summed
    a_done_claimed: assert property (@(posedge clk) disable iff (rst)
        done_i |-> state == S_CLAIM)
        else $error("checksum_core: done while the buffer is not claimed");

endmodule

`default_nettype wire

/* verilog/packet_ram.sv */
`timescale 1ns/100ps
`default_nettype none

// Packet buffer, one write port from capture and one read port for the core
module packet_ram import snoop_stream_pkg::*; (
    input  logic              clk,
    // Write port
    input  logic              wr_en_i,
    input  logic [ADDR_W-1:0] wr_addr_i,
    input  logic [DATA_W-1:0] wr_data_i,
    // Read port, data one cycle after the enable
    input  logic              rd_en_i,
    input  logic [ADDR_W-1:0] rd_addr_i,
    output logic [DATA_W-1:0] rd_data_o
);

    // Inferred block RAM
    logic [DATA_W-1:0] mem [BUF_WORDS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // Registered read, old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

/* verilog/snoop_capture.sv */
`timescale 1ns/100ps
`default_nettype none

// Passive AXI-Stream tap that writes observed packets into the packet buffer
module snoop_capture import snoop_stream_pkg::*; #(
    // Register the tapped stream before use
    parameter int PIPE_IN = 0
) (
    input  logic              clk,
    input  logic              rst,
    // Observed stream, never driven back
    input  logic [DATA_W-1:0] sn_tdata_i,
    input  logic [KEEP_W-1:0] sn_tkeep_i,
    input  logic              sn_tvalid_i,
    input  logic              sn_tready_i,
    input  logic              sn_tlast_i,
    // Buffer handshake with the core
    input  logic              buf_rdy_i,
    output logic              rdy_ack_o,
    // Buffer write port
    output logic [ADDR_W-1:0] wr_addr_o,
    output logic [DATA_W-1:0] wr_data_o,
    output logic              wr_en_o,
    output logic [INC_W-1:0]  byte_inc_o,
    // Packet events
    output logic              done_o,
    output logic              drop_o
);

    // Same encoding as the original tap machine
    typedef enum logic [1:0] {
        NOT_STARTED = 2'b00,
        WAITING     = 2'b01,
        STARTED     = 2'b11
    } cap_state_t;

    cap_state_t state;

    // Stream as seen by the capture logic
    logic [DATA_W-1:0] s_tdata;
    logic [KEEP_W-1:0] s_tkeep;
    logic              s_tvalid;
    logic              s_tready;
    logic              s_tlast;

    logic take;
    logic last_take;

    generate
        if (PIPE_IN != 0) begin : g_pipe
            logic [DATA_W-1:0] tdata_q;
            logic [KEEP_W-1:0] tkeep_q;
            logic              tvalid_q;
            logic              tready_q;
            logic              tlast_q;

            // Only valid needs a reset, the rest is qualified by it
            always_ff @(posedge clk) begin
                if (rst) begin
                    tvalid_q <= 1'b0;
                end else begin
                    tvalid_q <= sn_tvalid_i;
                end
                tdata_q <= sn_tdata_i;
                tkeep_q <= sn_tkeep_i;
                tready_q <= sn_tready_i;
                tlast_q <= sn_tlast_i;
            end

            assign s_tdata = tdata_q;
            assign s_tkeep = tkeep_q;
            assign s_tvalid = tvalid_q;
            assign s_tready = tready_q;
            assign s_tlast = tlast_q;
        end else begin : g_direct
            assign s_tdata = sn_tdata_i;
            assign s_tkeep = sn_tkeep_i;
            assign s_tvalid = sn_tvalid_i;
            assign s_tready = sn_tready_i;
            assign s_tlast = sn_tlast_i;
        end
    endgenerate

    // A beat counts only when both sides agree
    assign take = s_tvalid && s_tready;
    assign last_take = take && s_tlast;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= NOT_STARTED;
        end else begin
            case (state)
                NOT_STARTED: begin
                    // Buffer offered; a last beat on the same cycle
                    // closes the unknown packet right away
                    if (buf_rdy_i) begin
                        state <= last_take ? STARTED : WAITING;
                    end
                end
                WAITING: begin
                    // Skip the rest of a packet whose start was missed
                    if (last_take) begin
                        state <= STARTED;
                    end
                end
                STARTED: begin
                    if (last_take && !buf_rdy_i) begin
                        state <= NOT_STARTED;
                    end
                end
                default: state <= NOT_STARTED;
            endcase
        end
    end

    // Mealy outputs
    assign rdy_ack_o = (state == NOT_STARTED) || ((state == STARTED) && last_take);
    assign wr_en_o = (state == STARTED) && take;
    assign done_o = (state == STARTED) && last_take;
    // Last beat of a packet that was never written
    assign drop_o = (state != STARTED) && last_take;
    assign wr_data_o = s_tdata;

    // Word address inside the packet, back to 0 after each packet
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_addr_o <= '0;
        end else if (done_o) begin
            wr_addr_o <= '0;
        end else if (wr_en_o) begin
            wr_addr_o <= wr_addr_o + ADDR_W'(1);
        end
    end

    // Bytes in this beat, TKEEP population count
    always_comb begin
        byte_inc_o = '0;
        for (int i = 0; i < KEEP_W; i++) begin
            byte_inc_o = byte_inc_o + INC_W'(s_tkeep[i]);
        end
    end

    // Only the last beat may be partial
    a_full_keep: assert property (@(posedge clk) disable iff (rst)
        take && !s_tlast |-> s_tkeep == '1)
        else $error("snoop_capture: partial TKEEP on a non-last beat");

    // Lanes fill from lane 0 upward
    a_contig_keep: assert property (@(posedge clk) disable iff (rst)
        take |-> (s_tkeep & (s_tkeep + KEEP_W'(1))) == '0)
        else $error("snoop_capture: TKEEP not contiguous from lane 0");

    // A packet longer than the buffer would wrap onto word 0
    a_addr_bound: assert property (@(posedge clk) disable iff (rst)
        wr_en_o && !done_o |-> wr_addr_o != ADDR_W'(BUF_WORDS - 1))
        else $error("snoop_capture: packet overruns the buffer");

endmodule

`default_nettype wire

/* verilog/snoop_core_pkg.sv */
`default_nettype none

// Widths of the checksum result, packet length and statistics
package snoop_core_pkg;

    // Ones'-complement checksum width
    localparam int CSUM_W = 16;

    // Packet length in bytes
    // Up to 4096, one full buffer
    localparam int LEN_W = 13;

    // Packet and drop counters
    localparam int CNT_W = 16;

    // Captured byte counter
    localparam int BYTES_CNT_W = 32;

endpackage

`default_nettype wire

/* verilog/snoop_stats.sv */
`timescale 1ns/100ps
`default_nettype none

// Running statistics of the tap, all counters saturate
module snoop_stats import snoop_stream_pkg::*, snoop_core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   done_i,
    input  logic                   drop_i,
    input  logic [INC_W-1:0]       byte_inc_i,
    input  logic                   wr_en_i,
    output logic [CNT_W-1:0]       pkt_count_o,
    output logic [CNT_W-1:0]       drop_count_o,
    output logic [BYTES_CNT_W-1:0] byte_count_o
);

    // Byte sum with one carry bit for saturation
    logic [BYTES_CNT_W:0] byte_sum;

    assign byte_sum = {1'b0, byte_count_o} + (BYTES_CNT_W+1)'(byte_inc_i);

    always_ff @(posedge clk) begin
        if (rst) begin
            pkt_count_o <= '0;
            drop_count_o <= '0;
            byte_count_o <= '0;
        end else begin
            // Captured packets
            if (done_i && pkt_count_o != '1) begin
                pkt_count_o <= pkt_count_o + CNT_W'(1);
            end
            // Dropped packets
            if (drop_i && drop_count_o != '1) begin
                drop_count_o <= drop_count_o + CNT_W'(1);
            end
            // Only written beats reach the byte count
            if (wr_en_i) begin
                byte_count_o <= byte_sum[BYTES_CNT_W] ? '1 : byte_sum[BYTES_CNT_W-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/snoop_stream_pkg.sv */
`default_nettype none

// Geometry of the tapped AXI-Stream link and of the packet buffer
package snoop_stream_pkg;

    // One stream word
    localparam int DATA_W = 64;

    // Byte lanes per word, one TKEEP bit each
    localparam int KEEP_W = DATA_W / 8;

    // Buffer address width
    // 512 words of 8 bytes hold a 4 KiB packet
    localparam int ADDR_W = 9;

    // Buffer depth in words
    localparam int BUF_WORDS = 1 << ADDR_W;

    // Per-beat byte count, must hold 0 up to KEEP_W
    localparam int INC_W = 4;

endpackage

`default_nettype wire

/* verilog/snoop_top.sv */
`timescale 1ns/100ps
`default_nettype none

// Packet tap with on-line checksum and statistics
module snoop_top import snoop_stream_pkg::*, snoop_core_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // Observed stream
    input  logic [DATA_W-1:0]      sn_tdata_i,
    input  logic [KEEP_W-1:0]      sn_tkeep_i,
    input  logic                   sn_tvalid_i,
    input  logic                   sn_tready_i,
    input  logic                   sn_tlast_i,
    // Per-packet result
    output logic                   result_valid_o,
    output logic [CSUM_W-1:0]      result_csum_o,
    output logic [LEN_W-1:0]       result_len_o,
    // Statistics
    output logic [CNT_W-1:0]       pkt_count_o,
    output logic [CNT_W-1:0]       drop_count_o,
    output logic [BYTES_CNT_W-1:0] byte_count_o
);

    // Buffer write path
    logic [ADDR_W-1:0] wr_addr;
    logic [DATA_W-1:0] wr_data;
    logic              wr_en;
    logic [INC_W-1:0]  byte_inc;

    // Packet events and buffer handshake
    logic done;
    logic drop;
    logic buf_rdy;
    logic rdy_ack;

    // Buffer read path
    logic              rd_en;
    logic [ADDR_W-1:0] rd_addr;
    logic [DATA_W-1:0] rd_data;

    // Registered tap input eases timing at the link
    snoop_capture #(
        .PIPE_IN (1)
    ) u_capture (
        .clk         (clk),
        .rst         (rst),
        .sn_tdata_i  (sn_tdata_i),
        .sn_tkeep_i  (sn_tkeep_i),
        .sn_tvalid_i (sn_tvalid_i),
        .sn_tready_i (sn_tready_i),
        .sn_tlast_i  (sn_tlast_i),
        .buf_rdy_i   (buf_rdy),
        .rdy_ack_o   (rdy_ack),
        .wr_addr_o   (wr_addr),
        .wr_data_o   (wr_data),
        .wr_en_o     (wr_en),
        .byte_inc_o  (byte_inc),
        .done_o      (done),
        .drop_o      (drop)
    );

    packet_ram u_ram (
        .clk       (clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (rd_data)
    );

    checksum_core u_core (
        .clk            (clk),
        .rst            (rst),
        .wr_en_i        (wr_en),
        .byte_inc_i     (byte_inc),
        .done_i         (done),
        .rdy_ack_i      (rdy_ack),
        .buf_rdy_o      (buf_rdy),
        .rd_en_o        (rd_en),
        .rd_addr_o      (rd_addr),
        .rd_data_i      (rd_data),
        .result_valid_o (result_valid_o),
        .result_csum_o  (result_csum_o),
        .result_len_o   (result_len_o)
    );

    snoop_stats u_stats (
        .clk          (clk),
        .rst          (rst),
        .done_i       (done),
        .drop_i       (drop),
        .byte_inc_i   (byte_inc),
        .wr_en_i      (wr_en),
        .pkt_count_o  (pkt_count_o),
        .drop_count_o (drop_count_o),
        .byte_count_o (byte_count_o)
    );

endmodule

`default_nettype wire
